/* common/eth_udp_pkg.sv */
/*
 * Shared types for the UDP packet control logic
 * MAC, IPv4, port and length types plus the UDP header size
 */
`default_nettype none

package eth_udp_pkg;

  // Link and network layer addresses
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;

  // UDP header fields
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] udp_len_t;

  // UDP header bytes added to the payload length on send
  localparam udp_len_t UDP_HDR_BYTES = 16'd8;

endpackage

`default_nettype wire

/* common/udp_hdr_if.sv */
/*
 * Endpoint fields of one UDP header, with driver and receiver modports
 */
`timescale 1ns/1ps
`default_nettype none

interface udp_hdr_if;

  eth_udp_pkg::mac_addr_t  mac;
  eth_udp_pkg::ipv4_addr_t ip;
  eth_udp_pkg::udp_port_t  src_port;
  eth_udp_pkg::udp_port_t  dst_port;
  eth_udp_pkg::udp_len_t   length;

  // Side that drives the fields
  modport src (
    output mac, ip, src_port, dst_port, length
  );

  modport dst (
    input mac, ip, src_port, dst_port, length
  );

endinterface

`default_nettype wire

/* hdl/udp_rx_capture.sv */
/*
 * Receive header capture, holds the last UDP header seen from the stack
 */
`timescale 1ns/1ps
`default_nettype none

module udp_rx_capture (
  input  logic   i_clk_125MHz,
  input  logic   i_rst_int,
  input  logic   i_hdr_valid,
  udp_hdr_if.dst i_hdr,
  udp_hdr_if.src o_hdr
);

  eth_udp_pkg::mac_addr_t  mac_q;
  eth_udp_pkg::ipv4_addr_t ip_q;
  eth_udp_pkg::udp_port_t  src_port_q;
  eth_udp_pkg::udp_port_t  dst_port_q;
  eth_udp_pkg::udp_len_t   length_q;

  // Load on header valid, hold otherwise
  always_ff @(posedge i_clk_125MHz) begin
    if (i_rst_int) begin
      mac_q      <= '0;
      ip_q       <= '0;
      src_port_q <= '0;
      dst_port_q <= '0;
      length_q   <= '0;
    end else if (i_hdr_valid) begin
      mac_q      <= i_hdr.mac;
      ip_q       <= i_hdr.ip;
      src_port_q <= i_hdr.src_port;
      dst_port_q <= i_hdr.dst_port;
      length_q   <= i_hdr.length;
    end
  end

  // Held fields for the CSR side
  assign o_hdr.mac      = mac_q;
  assign o_hdr.ip       = ip_q;
  assign o_hdr.src_port = src_port_q;
  assign o_hdr.dst_port = dst_port_q;
  assign o_hdr.length   = length_q;

  // Captured header only changes after a new valid
  a_hold_without_valid : assert property (
    @(posedge i_clk_125MHz) disable iff (i_rst_int)
    (!i_rst_int && !i_hdr_valid) |=>
      $stable({mac_q, ip_q, src_port_q, dst_port_q, length_q})
  );

endmodule

`default_nettype wire

/* hdl/udp_tx_request.sv */
/*
 * Send request, header valid held until the stack takes it
 * Also drives the outbound FIFO start and both lengths
 */
`timescale 1ns/1ps
`default_nettype none

module udp_tx_request (
  input  logic                    i_clk_125MHz,
  input  logic                    i_rst_int,
  input  logic                    i_send_pkt,
  udp_hdr_if.dst                  i_send,
  input  logic                    i_hdr_ready,
  output logic                    o_hdr_valid,
  output eth_udp_pkg::mac_addr_t  o_dest_mac,
  output eth_udp_pkg::ipv4_addr_t o_dest_ip,
  output eth_udp_pkg::udp_port_t  o_src_port,
  output eth_udp_pkg::udp_port_t  o_dst_port,
  output eth_udp_pkg::udp_len_t   o_udp_length,
  output logic                    o_fifo_start,
  output eth_udp_pkg::udp_len_t   o_fifo_length
);

  logic req_pend;
  logic req_pend_next;

  // Pending request drops once the stack has seen ready
  always_comb begin
    req_pend_next = req_pend;
    if (req_pend) begin
      req_pend_next = !i_hdr_ready;
    end else if (i_send_pkt) begin
      req_pend_next = 1'b1;
    end
  end

  always_ff @(posedge i_clk_125MHz) begin
    if (i_rst_int) begin
      req_pend <= 1'b0;
    end else begin
      req_pend <= req_pend_next;
    end
  end

  assign o_hdr_valid  = req_pend;
  assign o_fifo_start = req_pend;

  assign o_dest_mac = i_send.mac;
  assign o_dest_ip  = i_send.ip;
  assign o_src_port = i_send.src_port;
  assign o_dst_port = i_send.dst_port;

  // Stack wants the length with the UDP header included
  assign o_fifo_length = i_send.length;
  assign o_udp_length  = i_send.length + eth_udp_pkg::UDP_HDR_BYTES;

  a_valid_until_ready : assert property (
    @(posedge i_clk_125MHz) disable iff (i_rst_int)
    (o_hdr_valid && !i_hdr_ready) |=> o_hdr_valid
  );

  // Destination and ports must not move under a pending header
  a_fields_stable : assert property (
    @(posedge i_clk_125MHz) disable iff (i_rst_int)
    (o_hdr_valid && !i_hdr_ready) |=>
      $stable({o_dest_mac, o_dest_ip, o_src_port, o_dst_port})
  );

endmodule

`default_nettype wire

/* hdl/pkt_irq_ctrl.sv */
/*
 * Packet received and packet sent interrupt flags
 */
`timescale 1ns/1ps
`default_nettype none

module pkt_irq_ctrl (
  input  logic i_clk_125MHz,
  input  logic i_rst_int,
  input  logic i_rx_done,
  input  logic i_tx_done,
  input  logic i_clear_irq,
  output logic o_pkt_recv,
  output logic o_pkt_sent
);

  logic irq_rx;
  logic irq_tx;

  // Clear beats a done pulse in the same cycle
  always_ff @(posedge i_clk_125MHz) begin
    if (i_rst_int) begin
      irq_rx <= 1'b0;
      irq_tx <= 1'b0;
    end else if (i_clear_irq) begin
      irq_rx <= 1'b0;
      irq_tx <= 1'b0;
    end else begin
      if (i_rx_done) begin
        irq_rx <= 1'b1;
      end
      if (i_tx_done) begin
        irq_tx <= 1'b1;
      end
    end
  end

  assign o_pkt_recv = irq_rx;
  assign o_pkt_sent = irq_tx;

  a_clear_wins : assert property (
    @(posedge i_clk_125MHz) disable iff (i_rst_int)
    i_clear_irq |=> (!o_pkt_recv && !o_pkt_sent)
  );

endmodule

`default_nettype wire

/* hdl/udp_pkt_ctrl.sv */
/*
 * UDP packet control top level
 * Receive capture, send request and interrupt flags
 */
`timescale 1ns/1ps
`default_nettype none

module udp_pkt_ctrl (
  input  logic                    i_clk_125MHz,
  input  logic                    i_rst_int,
  // Received header from the stack
  input  logic                    i_rx_hdr_valid,
  input  eth_udp_pkg::mac_addr_t  i_rx_mac,
  input  eth_udp_pkg::ipv4_addr_t i_rx_ip,
  input  eth_udp_pkg::udp_port_t  i_rx_src_port,
  input  eth_udp_pkg::udp_port_t  i_rx_dst_port,
  input  eth_udp_pkg::udp_len_t   i_rx_length,
  // Send command and fields from the CSR side
  input  logic                    i_send_pkt,
  input  eth_udp_pkg::mac_addr_t  i_send_mac,
  input  eth_udp_pkg::ipv4_addr_t i_send_ip,
  input  eth_udp_pkg::udp_port_t  i_send_src_port,
  input  eth_udp_pkg::udp_port_t  i_send_dst_port,
  input  eth_udp_pkg::udp_len_t   i_send_length,
  input  logic                    i_tx_hdr_ready,
  input  logic                    i_rx_fifo_done,
  input  logic                    i_tx_fifo_done,
  input  logic                    i_clear_irq,
  // Held receive header
  output eth_udp_pkg::mac_addr_t  o_recv_mac,
  output eth_udp_pkg::ipv4_addr_t o_recv_ip,
  output eth_udp_pkg::udp_port_t  o_recv_src_port,
  output eth_udp_pkg::udp_port_t  o_recv_dst_port,
  output eth_udp_pkg::udp_len_t   o_recv_length,
  // Stack side of the send header
  output logic                    o_tx_hdr_valid,
  output eth_udp_pkg::mac_addr_t  o_tx_dest_mac,
  output eth_udp_pkg::ipv4_addr_t o_tx_dest_ip,
  output eth_udp_pkg::udp_port_t  o_tx_src_port,
  output eth_udp_pkg::udp_port_t  o_tx_dst_port,
  output eth_udp_pkg::udp_len_t   o_tx_udp_length,
  output logic                    o_tx_fifo_start,
  output eth_udp_pkg::udp_len_t   o_tx_fifo_length,
  // Interrupts
  output logic                    o_pkt_recv,
  output logic                    o_pkt_sent
);

  udp_hdr_if rx_hdr ();
  udp_hdr_if recv_hdr ();
  udp_hdr_if send_hdr ();

  assign rx_hdr.mac      = i_rx_mac;
  assign rx_hdr.ip       = i_rx_ip;
  assign rx_hdr.src_port = i_rx_src_port;
  assign rx_hdr.dst_port = i_rx_dst_port;
  assign rx_hdr.length   = i_rx_length;

  assign send_hdr.mac      = i_send_mac;
  assign send_hdr.ip       = i_send_ip;
  assign send_hdr.src_port = i_send_src_port;
  assign send_hdr.dst_port = i_send_dst_port;
  assign send_hdr.length   = i_send_length;

  assign o_recv_mac      = recv_hdr.mac;
  assign o_recv_ip       = recv_hdr.ip;
  assign o_recv_src_port = recv_hdr.src_port;
  assign o_recv_dst_port = recv_hdr.dst_port;
  assign o_recv_length   = recv_hdr.length;

  udp_rx_capture u_udp_rx_capture (
    .i_clk_125MHz (i_clk_125MHz),
    .i_rst_int    (i_rst_int),
    .i_hdr_valid  (i_rx_hdr_valid),
    .i_hdr        (rx_hdr.dst),
    .o_hdr        (recv_hdr.src)
  );

  udp_tx_request u_udp_tx_request (
    .i_clk_125MHz  (i_clk_125MHz),
    .i_rst_int     (i_rst_int),
    .i_send_pkt    (i_send_pkt),
    .i_send        (send_hdr.dst),
    .i_hdr_ready   (i_tx_hdr_ready),
    .o_hdr_valid   (o_tx_hdr_valid),
    .o_dest_mac    (o_tx_dest_mac),
    .o_dest_ip     (o_tx_dest_ip),
    .o_src_port    (o_tx_src_port),
    .o_dst_port    (o_tx_dst_port),
    .o_udp_length  (o_tx_udp_length),
    .o_fifo_start  (o_tx_fifo_start),
    .o_fifo_length (o_tx_fifo_length)
  );

  pkt_irq_ctrl u_pkt_irq_ctrl (
    .i_clk_125MHz (i_clk_125MHz),
    .i_rst_int    (i_rst_int),
    .i_rx_done    (i_rx_fifo_done),
    .i_tx_done    (i_tx_fifo_done),
    .i_clear_irq  (i_clear_irq),
    .o_pkt_recv   (o_pkt_recv),
    .o_pkt_sent   (o_pkt_sent)
  );

endmodule

`default_nettype wire

/* tb/tb_udp_pkt_ctrl.sv */
/*
 * Directed testbench for udp_pkt_ctrl
 * Clock, reset, test tasks, compare tasks and watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_udp_pkt_ctrl;

  localparam int CLK_PERIOD_NS = 8;
  localparam int RESET_CYCLES  = 4;
  // Worst case cycles of reset check, rx, tx, irq set and irq clear
  localparam int TEST_CYCLES   = 1 + 3 + 12 + 5 + 3;
  localparam int WATCHDOG_NS   = (TEST_CYCLES * 2 + RESET_CYCLES) * CLK_PERIOD_NS;

  logic clk_125MHz;
  logic rst_int;

  logic                    i_rx_hdr_valid;
  eth_udp_pkg::mac_addr_t  i_rx_mac;
  eth_udp_pkg::ipv4_addr_t i_rx_ip;
  eth_udp_pkg::udp_port_t  i_rx_src_port, i_rx_dst_port;
  eth_udp_pkg::udp_len_t   i_rx_length;
  logic                    i_send_pkt;
  eth_udp_pkg::mac_addr_t  i_send_mac;
  eth_udp_pkg::ipv4_addr_t i_send_ip;
  eth_udp_pkg::udp_port_t  i_send_src_port, i_send_dst_port;
  eth_udp_pkg::udp_len_t   i_send_length;
  logic                    i_tx_hdr_ready, i_rx_fifo_done, i_tx_fifo_done, i_clear_irq;
  eth_udp_pkg::mac_addr_t  o_recv_mac, o_tx_dest_mac;
  eth_udp_pkg::ipv4_addr_t o_recv_ip, o_tx_dest_ip;
  eth_udp_pkg::udp_port_t  o_recv_src_port, o_recv_dst_port, o_tx_src_port, o_tx_dst_port;
  eth_udp_pkg::udp_len_t   o_recv_length, o_tx_udp_length, o_tx_fifo_length;
  logic                    o_tx_hdr_valid, o_tx_fifo_start, o_pkt_recv, o_pkt_sent;

  int error_count;
  int check_count;

  udp_pkt_ctrl u_dut (
    .i_clk_125MHz (clk_125MHz),
    .i_rst_int    (rst_int),
    .*
  );

  initial begin
    clk_125MHz = 1'b0;
    forever begin
      #(CLK_PERIOD_NS / 2) clk_125MHz = ~clk_125MHz;
    end
  end

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_125MHz);
    #1;
  endtask

  task automatic check_hdr(
    input string                   name,
    input eth_udp_pkg::mac_addr_t  exp_mac,
    input eth_udp_pkg::ipv4_addr_t exp_ip,
    input eth_udp_pkg::udp_port_t  exp_src,
    input eth_udp_pkg::udp_port_t  exp_dst,
    input eth_udp_pkg::udp_len_t   exp_len,
    input eth_udp_pkg::mac_addr_t  act_mac,
    input eth_udp_pkg::ipv4_addr_t act_ip,
    input eth_udp_pkg::udp_port_t  act_src,
    input eth_udp_pkg::udp_port_t  act_dst,
    input eth_udp_pkg::udp_len_t   act_len
  );
    check_count++;
    if ({exp_mac, exp_ip, exp_src, exp_dst, exp_len} !==
        {act_mac, act_ip, act_src, act_dst, act_len}) begin
      error_count++;
      $display("Error: %s expected %h actual %h", name,
               {exp_mac, exp_ip, exp_src, exp_dst, exp_len},
               {act_mac, act_ip, act_src, act_dst, act_len});
    end
  endtask

  task automatic check_len(input string name, input eth_udp_pkg::udp_len_t exp_len,
                           input eth_udp_pkg::udp_len_t act_len);
    check_count++;
    if (exp_len !== act_len) begin
      error_count++;
      $display("Error: %s expected %h actual %h", name, exp_len, act_len);
    end
  endtask

  task automatic check_flag(input string name, input logic exp_flag, input logic act_flag);
    check_count++;
    if (exp_flag !== act_flag) begin
      error_count++;
      $display("Error: %s expected %b actual %b", name, exp_flag, act_flag);
    end
  endtask

  task automatic test_after_reset();
    next_cycle();
    check_flag("after_reset hdr_valid", 1'b0, o_tx_hdr_valid);
    check_flag("after_reset fifo_start", 1'b0, o_tx_fifo_start);
    check_flag("after_reset pkt_recv", 1'b0, o_pkt_recv);
    check_flag("after_reset pkt_sent", 1'b0, o_pkt_sent);
    check_hdr("after_reset recv", '0, '0, '0, '0, '0, o_recv_mac, o_recv_ip,
              o_recv_src_port, o_recv_dst_port, o_recv_length);
  endtask

  task automatic test_rx_capture();
    eth_udp_pkg::mac_addr_t  mac;
    eth_udp_pkg::ipv4_addr_t ip;
    eth_udp_pkg::udp_port_t  src_port;
    eth_udp_pkg::udp_port_t  dst_port;
    eth_udp_pkg::udp_len_t   length;
    mac      = {16'($urandom), 32'($urandom)};
    ip       = 32'($urandom);
    src_port = 16'($urandom);
    dst_port = 16'($urandom);
    length   = 16'($urandom);
    i_rx_mac       = mac;
    i_rx_ip        = ip;
    i_rx_src_port  = src_port;
    i_rx_dst_port  = dst_port;
    i_rx_length    = length;
    i_rx_hdr_valid = 1'b1;
    next_cycle();
    i_rx_hdr_valid = 1'b0;
    check_hdr("rx_capture load", mac, ip, src_port, dst_port, length, o_recv_mac,
              o_recv_ip, o_recv_src_port, o_recv_dst_port, o_recv_length);
    // New fields without valid
    i_rx_mac      = ~mac;
    i_rx_ip       = ~ip;
    i_rx_src_port = ~src_port;
    i_rx_dst_port = ~dst_port;
    i_rx_length   = ~length;
    next_cycle();
    next_cycle();
    check_hdr("rx_capture hold", mac, ip, src_port, dst_port, length, o_recv_mac,
              o_recv_ip, o_recv_src_port, o_recv_dst_port, o_recv_length);
  endtask

  task automatic test_send_request();
    eth_udp_pkg::udp_len_t length;
    int unsigned           wait_cycles;
    length          = 16'($urandom_range(1, 1472));
    i_send_mac      = {16'($urandom), 32'($urandom)};
    i_send_ip       = 32'($urandom);
    i_send_src_port = 16'($urandom);
    i_send_dst_port = 16'($urandom);
    i_send_length   = length;
    i_tx_hdr_ready  = 1'b0;
    i_send_pkt      = 1'b1;
    next_cycle();
    i_send_pkt = 1'b0;
    check_flag("send hdr_valid rise", 1'b1, o_tx_hdr_valid);
    check_flag("send fifo_start rise", 1'b1, o_tx_fifo_start);
    check_hdr("send fields", i_send_mac, i_send_ip, i_send_src_port, i_send_dst_port,
              length, o_tx_dest_mac, o_tx_dest_ip, o_tx_src_port, o_tx_dst_port,
              o_tx_fifo_length);
    // UDP length counts the 8 header bytes
    check_len("send udp_length", length + 16'd8, o_tx_udp_length);
    wait_cycles = $urandom_range(0, 10);
    repeat (wait_cycles) begin
      next_cycle();
      check_flag("send hdr_valid held", 1'b1, o_tx_hdr_valid);
    end
    i_tx_hdr_ready = 1'b1;
    next_cycle();
    i_tx_hdr_ready = 1'b0;
    check_flag("send hdr_valid fall", 1'b0, o_tx_hdr_valid);
    check_flag("send fifo_start fall", 1'b0, o_tx_fifo_start);
  endtask

  task automatic test_irq_set();
    i_rx_fifo_done = 1'b1;
    next_cycle();
    i_rx_fifo_done = 1'b0;
    check_flag("irq_set rx pkt_recv", 1'b1, o_pkt_recv);
    check_flag("irq_set rx pkt_sent", 1'b0, o_pkt_sent);
    i_tx_fifo_done = 1'b1;
    next_cycle();
    i_tx_fifo_done = 1'b0;
    check_flag("irq_set tx pkt_sent", 1'b1, o_pkt_sent);
    repeat (3) begin
      next_cycle();
    end
    check_flag("irq_set idle pkt_recv", 1'b1, o_pkt_recv);
    check_flag("irq_set idle pkt_sent", 1'b1, o_pkt_sent);
  endtask

  task automatic test_irq_clear();
    i_clear_irq = 1'b1;
    next_cycle();
    i_clear_irq = 1'b0;
    check_flag("irq_clear pkt_recv", 1'b0, o_pkt_recv);
    check_flag("irq_clear pkt_sent", 1'b0, o_pkt_sent);
    i_rx_fifo_done = 1'b1;
    next_cycle();
    // Clear together with both done pulses
    i_clear_irq    = 1'b1;
    i_tx_fifo_done = 1'b1;
    next_cycle();
    i_clear_irq    = 1'b0;
    i_rx_fifo_done = 1'b0;
    i_tx_fifo_done = 1'b0;
    check_flag("irq_clear wins pkt_recv", 1'b0, o_pkt_recv);
    check_flag("irq_clear wins pkt_sent", 1'b0, o_pkt_sent);
  endtask

  initial begin
    void'($urandom(32'h229f8dc6));
    error_count     = 0;
    check_count     = 0;
    rst_int         = 1'b1;
    i_rx_hdr_valid  = 1'b0;
    i_rx_mac        = '0;
    i_rx_ip         = '0;
    i_rx_src_port   = '0;
    i_rx_dst_port   = '0;
    i_rx_length     = '0;
    i_send_pkt      = 1'b0;
    i_send_mac      = '0;
    i_send_ip       = '0;
    i_send_src_port = '0;
    i_send_dst_port = '0;
    i_send_length   = '0;
    i_tx_hdr_ready  = 1'b0;
    i_rx_fifo_done  = 1'b0;
    i_tx_fifo_done  = 1'b0;
    i_clear_irq     = 1'b0;
    repeat (RESET_CYCLES) begin
      @(posedge clk_125MHz);
    end
    #1;
    rst_int = 1'b0;
    test_after_reset();
    test_rx_capture();
    test_send_request();
    test_irq_set();
    test_irq_clear();
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
common/eth_udp_pkg.sv
common/udp_hdr_if.sv
hdl/udp_rx_capture.sv
hdl/udp_tx_request.sv
hdl/pkt_irq_ctrl.sv
hdl/udp_pkt_ctrl.sv
tb/tb_udp_pkt_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_udp_pkt_ctrl
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "Checks failed" $(LOG); then \
	  echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
